// File: src.f
hw/soc_map_pkg.sv
hw/bus_pkg.sv
hw/periph_bus_ctrl.sv
hw/mtimer.sv
hw/gpio_regs.sv
hw/pwm_bank.sv
hw/periph_subsystem.sv
sim/tb_periph_subsystem.sv

// File: Makefile
TOP = tb_periph_subsystem

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ns -f src.f --top-module periph_subsystem
	verilator --lint-only --timing --assert --timescale 1ns/1ns -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -f src.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

// File: sim/tb_periph_subsystem.sv
// ************************************************************
// Testbench for the peripheral subsystem: host bus task,
// stimulus, concurrent assertions, watchdog and report
// ************************************************************
`timescale 1ns/1ns

module tb_periph_subsystem;

  import soc_map_pkg::*;
  import bus_pkg::*;

  localparam int ClkPeriod = 100;
  localparam int GpoWrites = 12;
  localparam int PwmRuns   = 3;
  // Reset, about four cycles per access, interrupt wait and PWM windows
  localparam int TestCycles = 10 + 4 * (GpoWrites + 12 + 2 * PwmRuns) + 70 + PwmRuns * 3 * 17;

  logic        clk_sys_i    = 1'b0;
  logic        rst_sys_ni   = 1'b0;
  logic        host_req_i   = 1'b0;
  logic [31:0] host_addr_i  = '0;
  logic        host_we_i    = 1'b0;
  logic [3:0]  host_be_i    = '0;
  logic [31:0] host_wdata_i = '0;
  logic [7:0]  gp_i         = '0;
  logic        host_gnt_o;
  logic        host_rvalid_o;
  logic        host_err_o;
  logic        timer_irq_o;
  logic [31:0] host_rdata_o;
  logic [15:0] gp_o;
  logic [11:0] pwm_o;

  integer      seed        = 70404;
  int          err_proto   = 0;
  int          err_data    = 0;
  logic        exp_data_en = 1'b0;  // Expected response of the pending access
  logic [31:0] exp_rdata   = '0;
  logic        exp_err     = 1'b0;
  logic [15:0] gpo_sb      = '0;    // Scoreboard of the GPIO output register
  logic        chk_reset   = 1'b0;
  logic        chk_gpo     = 1'b0;
  logic        chk_irq_low = 1'b0;
  logic        wait_irq    = 1'b0;
  int          irq_wait    = 0;
  logic        chk_time    = 1'b0;
  logic [31:0] time_a      = '0;
  logic [31:0] time_b      = '0;
  logic        pwm_track   = 1'b0;
  logic [3:0]  pwm_ch      = '0;
  int          pwm_p       = 1;
  int          pwm_w       = 0;
  int          pwm_fill    = 0;
  int          pwm_cnt;
  logic [63:0] pwm_hist    = '0;    // Newest sample in bit 0

  always #(ClkPeriod / 2) clk_sys_i = ~clk_sys_i;

  periph_subsystem #(
    .GpiWidth (8),
    .GpoWidth (16),
    .PwmWidth (12)
  ) u_periph_subsystem (
    .clk_sys_i     (clk_sys_i),
    .rst_sys_ni    (rst_sys_ni),
    .host_req_i    (host_req_i),
    .host_gnt_o    (host_gnt_o),
    .host_addr_i   (host_addr_i),
    .host_we_i     (host_we_i),
    .host_be_i     (host_be_i),
    .host_wdata_i  (host_wdata_i),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .host_err_o    (host_err_o),
    .gp_i          (gp_i),
    .gp_o          (gp_o),
    .pwm_o         (pwm_o),
    .timer_irq_o   (timer_irq_o)
  );

  // Only the two low bytes of the word reach the 16-bit output register
  function automatic logic [15:0] merge_gpo(input logic [15:0] cur, input logic [31:0] data,
                                            input logic [3:0] be);
    logic [15:0] res;
    res = cur;
    if (be[0]) res[7:0] = data[7:0];
    if (be[1]) res[15:8] = data[15:8];
    return res;
  endfunction

  // One host access, request held until grant, then the response is awaited
  task automatic bus_xfer(input logic [31:0] addr, input logic we, input logic [3:0] be,
                          input logic [31:0] wdata, input logic chk_data,
                          input logic [31:0] exp_data, input logic exp_e,
                          output logic [31:0] rdata);
    @(posedge clk_sys_i);
    host_req_i   <= 1'b1;
    host_addr_i  <= addr;
    host_we_i    <= we;
    host_be_i    <= be;
    host_wdata_i <= wdata;
    exp_data_en  <= chk_data;
    exp_rdata    <= exp_data;
    exp_err      <= exp_e;
    @(negedge clk_sys_i);
    while (!host_gnt_o) @(negedge clk_sys_i);
    @(posedge clk_sys_i);  // Accepting edge
    host_req_i <= 1'b0;
    @(negedge clk_sys_i);
    while (!host_rvalid_o) @(negedge clk_sys_i);
    rdata = host_rdata_o;
  endtask

  always @(posedge clk_sys_i) begin
    if (wait_irq && !timer_irq_o) irq_wait <= irq_wait + 1;
    else if (!wait_irq) irq_wait <= 0;
  end

  always @(posedge clk_sys_i) begin
    if (!pwm_track) begin
      pwm_hist <= '0;
      pwm_fill <= 0;
    end else begin
      pwm_hist <= {pwm_hist[62:0], pwm_o[pwm_ch]};
      pwm_fill <= pwm_fill + 1;
    end
  end

  always_comb pwm_cnt = $countones(pwm_hist & ((64'd1 << (pwm_p + 1)) - 64'd1));

  a_resp_timing: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
                                  host_rvalid_o == $past(host_gnt_o))
    else begin
      err_proto = err_proto + 1;
      $display("[ERROR] %0t: response not exactly one cycle after grant", $time);
    end
  a_gnt_rule: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
                               host_gnt_o == (host_req_i && !host_rvalid_o))
    else begin
      err_proto = err_proto + 1;
      $display("[ERROR] %0t: grant does not follow request in idle", $time);
    end
  a_err_in_resp: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
                                  host_err_o |-> host_rvalid_o)
    else begin
      err_proto = err_proto + 1;
      $display("[ERROR] %0t: error flag outside a response cycle", $time);
    end
  a_wr_zero: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
                              host_rvalid_o && $past(host_we_i) |-> host_rdata_o == '0)
    else begin
      err_proto = err_proto + 1;
      $display("[ERROR] %0t: write response carries nonzero data", $time);
    end
  a_err_flag: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
                               host_rvalid_o |-> host_err_o == exp_err)
    else begin
      err_data = err_data + 1;
      $display("[ERROR] %0t: error flag %0b, expected %0b", $time,
               $sampled(host_err_o), $sampled(exp_err));
    end
  a_rdata: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
                            host_rvalid_o && exp_data_en |-> host_rdata_o == exp_rdata)
    else begin
      err_data = err_data + 1;
      $display("[ERROR] %0t: read data %h, expected %h", $time,
               $sampled(host_rdata_o), $sampled(exp_rdata));
    end
  a_reset_low: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
                                chk_reset |-> !host_rvalid_o && !host_err_o && !timer_irq_o
                                              && pwm_o == '0 && gp_o == '0)
    else begin
      err_data = err_data + 1;
      $display("[ERROR] %0t: outputs not low after reset", $time);
    end
  a_gpo: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
                          chk_gpo |-> gp_o == gpo_sb)
    else begin
      err_data = err_data + 1;
      $display("[ERROR] %0t: gp_o %h, expected %h", $time, $sampled(gp_o), $sampled(gpo_sb));
    end
  a_irq_low: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
                              chk_irq_low |-> !timer_irq_o)
    else begin
      err_data = err_data + 1;
      $display("[ERROR] %0t: timer interrupt high while compare is ahead", $time);
    end
  a_irq_rise: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni) irq_wait <= 60)
    else begin
      err_data = err_data + 1;
      $display("[ERROR] %0t: timer interrupt did not rise within 60 cycles", $time);
    end
  a_time_inc: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
                               chk_time |-> time_b > time_a)
    else begin
      err_data = err_data + 1;
      $display("[ERROR] %0t: mtime did not increase, %0d then %0d", $time,
               $sampled(time_a), $sampled(time_b));
    end
  a_pwm_window: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
                                 pwm_track && pwm_fill > pwm_p |-> pwm_cnt == pwm_w)
    else begin
      err_data = err_data + 1;
      $display("[ERROR] %0t: PWM channel %0d high %0d cycles per window, expected %0d",
               $time, $sampled(pwm_ch), $sampled(pwm_cnt), $sampled(pwm_w));
    end

  initial begin
    logic [31:0] rd;
    logic [31:0] wd;
    logic [3:0]  be;
    logic [7:0]  gpi;
    logic [31:0] tval;
    repeat (5) @(posedge clk_sys_i);
    rst_sys_ni <= 1'b1;
    chk_reset  <= 1'b1;
    repeat (2) @(posedge clk_sys_i);
    chk_reset  <= 1'b0;

    for (int i = 0; i < GpoWrites; i++) begin
      wd = $random(seed);
      be = 4'($random(seed));
      bus_xfer(GPIO_START | 32'(GPIO_OUT_OFS), 1'b1, be, wd, 1'b1, '0, 1'b0, rd);
      gpo_sb = merge_gpo(gpo_sb, wd, be);
    end
    @(posedge clk_sys_i);
    chk_gpo <= 1'b1;
    bus_xfer(GPIO_START | 32'(GPIO_OUT_OFS), 1'b0, 4'hF, '0, 1'b1, {16'h0, gpo_sb}, 1'b0, rd);

    gpi = 8'($random(seed));
    @(posedge clk_sys_i);
    gp_i <= gpi;
    repeat (3) @(posedge clk_sys_i);
    bus_xfer(GPIO_START | 32'(GPIO_IN_OFS), 1'b0, 4'hF, '0, 1'b1, 32'(gpi), 1'b0, rd);

    // Hole between GPIO and timer, then far outside the map
    bus_xfer(32'h8000_1000, 1'b0, 4'hF, '0, 1'b1, '0, 1'b1, rd);
    bus_xfer(32'h9000_0000, 1'b1, 4'hF, 32'hFFFF_FFFF, 1'b1, '0, 1'b1, rd);
    bus_xfer(GPIO_START | 32'(GPIO_OUT_OFS), 1'b0, 4'hF, '0, 1'b1, {16'h0, gpo_sb}, 1'b0, rd);

    bus_xfer(TIMER_START | 32'(MTIME_LO_OFS), 1'b0, 4'hF, '0, 1'b0, '0, 1'b0, tval);
    bus_xfer(TIMER_START | 32'(MTIMECMP_LO_OFS), 1'b1, 4'hF, tval + 32'd40, 1'b0, '0, 1'b0, rd);
    bus_xfer(TIMER_START | 32'(MTIMECMP_HI_OFS), 1'b1, 4'hF, 32'h0, 1'b0, '0, 1'b0, rd);
    @(posedge clk_sys_i);
    chk_irq_low <= 1'b1;
    @(posedge clk_sys_i);
    chk_irq_low <= 1'b0;
    wait_irq    <= 1'b1;
    @(negedge clk_sys_i);
    while (!timer_irq_o && irq_wait <= 60) @(negedge clk_sys_i);
    @(posedge clk_sys_i);
    wait_irq <= 1'b0;
    bus_xfer(TIMER_START | 32'(MTIMECMP_HI_OFS), 1'b1, 4'hF, '1, 1'b0, '0, 1'b0, rd);
    @(posedge clk_sys_i);
    chk_irq_low <= 1'b1;  // Cleared two edges after the write
    bus_xfer(TIMER_START | 32'(MTIMECMP_LO_OFS), 1'b1, 4'hF, '1, 1'b0, '0, 1'b0, rd);
    bus_xfer(TIMER_START | 32'(MTIME_LO_OFS), 1'b0, 4'hF, '0, 1'b0, '0, 1'b0, time_a);
    bus_xfer(TIMER_START | 32'(MTIME_LO_OFS), 1'b0, 4'hF, '0, 1'b0, '0, 1'b0, time_b);
    @(posedge clk_sys_i);
    chk_time <= 1'b1;
    @(posedge clk_sys_i);
    chk_time    <= 1'b0;
    chk_irq_low <= 1'b0;

    for (int r = 0; r < PwmRuns; r++) begin
      @(posedge clk_sys_i);
      pwm_track <= 1'b0;
      @(negedge clk_sys_i);
      pwm_ch = 4'($unsigned($random(seed)) % 12);
      pwm_p  = 1 + ($unsigned($random(seed)) % 16);
      pwm_w  = $unsigned($random(seed)) % (pwm_p + 1);
      wd     = {pwm_w[15:0], pwm_p[15:0]};
      bus_xfer(PWM_START | {26'd0, pwm_ch, 2'b00}, 1'b1, 4'hF, wd, 1'b0, '0, 1'b0, rd);
      @(posedge clk_sys_i);
      pwm_track <= 1'b1;  // First sample lands two edges after the write
      bus_xfer(PWM_START | {26'd0, pwm_ch, 2'b00}, 1'b0, 4'hF, '0, 1'b1, wd, 1'b0, rd);
      repeat (3 * (pwm_p + 1)) @(posedge clk_sys_i);
    end
    pwm_track <= 1'b0;
    repeat (2) @(posedge clk_sys_i);

    $display("Errors: protocol %0d, data %0d", err_proto, err_data);
    if (err_proto + err_data == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Twice the expected run length
  initial begin
    #(2 * TestCycles * ClkPeriod);
    $display("Run timed out, the test sequence did not reach its end");
    $display("TEST FAIL");
    $finish;
  end

endmodule

// File: hw/periph_subsystem.sv
// *********************************************************
// Peripheral subsystem top: bus controller, GPIO, machine
// timer and PWM bank
// *********************************************************
`timescale 1ns/1ns

module periph_subsystem #(
  parameter int GpiWidth = 8,
  parameter int GpoWidth = 16,
  parameter int PwmWidth = 12
) (
  input  logic                        clk_sys_i,
  input  logic                        rst_sys_ni,

  // Host bus
  input  logic                        host_req_i,
  output logic                        host_gnt_o,
  input  logic [bus_pkg::BUS_AW-1:0]  host_addr_i,
  input  logic                        host_we_i,
  input  logic [bus_pkg::BUS_BEW-1:0] host_be_i,
  input  logic [bus_pkg::BUS_DW-1:0]  host_wdata_i,
  output logic                        host_rvalid_o,
  output logic [bus_pkg::BUS_DW-1:0]  host_rdata_o,
  output logic                        host_err_o,

  input  logic [GpiWidth-1:0]         gp_i,
  output logic [GpoWidth-1:0]         gp_o,
  output logic [PwmWidth-1:0]         pwm_o,
  output logic                        timer_irq_o
);

  import soc_map_pkg::*;
  import bus_pkg::*;

  logic [NR_DEVICES-1:0] dev_req;
  logic [OFFSET_W-1:0]   dev_offset;
  logic                  dev_we;
  logic [BUS_BEW-1:0]    dev_be;
  logic [BUS_DW-1:0]     dev_wdata;
  logic [BUS_DW-1:0]     dev_rdata [NR_DEVICES];

  periph_bus_ctrl u_bus_ctrl (
    .clk_sys_i     (clk_sys_i),
    .rst_sys_ni    (rst_sys_ni),
    .host_req_i    (host_req_i),
    .host_gnt_o    (host_gnt_o),
    .host_addr_i   (host_addr_i),
    .host_we_i     (host_we_i),
    .host_be_i     (host_be_i),
    .host_wdata_i  (host_wdata_i),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .host_err_o    (host_err_o),
    .dev_req_o     (dev_req),
    .dev_offset_o  (dev_offset),
    .dev_we_o      (dev_we),
    .dev_be_o      (dev_be),
    .dev_wdata_o   (dev_wdata),
    .dev_rdata_i   (dev_rdata)
  );

  gpio_regs #(
    .GpiWidth (GpiWidth),
    .GpoWidth (GpoWidth)
  ) u_gpio (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .req_i      (dev_req[Gpio]),
    .we_i       (dev_we),
    .offset_i   (dev_offset),
    .be_i       (dev_be),
    .wdata_i    (dev_wdata),
    .rdata_o    (dev_rdata[Gpio]),
    .gp_i       (gp_i),
    .gp_o       (gp_o)
  );

  mtimer u_timer (
    .clk_sys_i   (clk_sys_i),
    .rst_sys_ni  (rst_sys_ni),
    .req_i       (dev_req[Timer]),
    .we_i        (dev_we),
    .offset_i    (dev_offset),
    .be_i        (dev_be),
    .wdata_i     (dev_wdata),
    .rdata_o     (dev_rdata[Timer]),
    .timer_irq_o (timer_irq_o)
  );

  pwm_bank #(
    .PwmWidth (PwmWidth)
  ) u_pwm (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .req_i      (dev_req[Pwm]),
    .we_i       (dev_we),
    .offset_i   (dev_offset),
    .be_i       (dev_be),
    .wdata_i    (dev_wdata),
    .rdata_o    (dev_rdata[Pwm]),
    .pwm_o      (pwm_o)
  );

endmodule

// File: hw/pwm_bank.sv
// *********************************************************
// PWM bank: one configuration word, counter and registered
// comparator per channel
// *********************************************************
`timescale 1ns/1ns

module pwm_bank #(
  parameter int PwmWidth = 12
) (
  input  logic                         clk_sys_i,
  input  logic                         rst_sys_ni,

  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [bus_pkg::OFFSET_W-1:0] offset_i,
  input  logic [bus_pkg::BUS_BEW-1:0]  be_i,
  input  logic [bus_pkg::BUS_DW-1:0]   wdata_i,
  output logic [bus_pkg::BUS_DW-1:0]   rdata_o,

  output logic [PwmWidth-1:0]          pwm_o
);

  import bus_pkg::*;

  logic [OFFSET_W-3:0]               ch_idx;   // Word index, channel n at 4n
  logic [PwmWidth-1:0][BUS_DW-1:0]   cfg_raw;  // Read-back view of every channel

  assign ch_idx = offset_i[OFFSET_W-1:2];

  for (genvar n = 0; n < PwmWidth; n++) begin : g_chan
    pwm_cfg_u             cfg_q;
    logic [PWM_CTR_W-1:0] ctr_q;
    logic                 out_q;
    logic                 cfg_wr;

    assign cfg_wr = req_i & we_i & (ch_idx == n);

    always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
      if (!rst_sys_ni) begin
        cfg_q.raw <= '0;
        ctr_q     <= '0;
        out_q     <= 1'b0;
      end else begin
        if (cfg_wr) begin
          cfg_q.raw <= be_merge(cfg_q.raw, wdata_i, be_i);
          ctr_q     <= '0;  // New setting starts a fresh period
        end else if (ctr_q >= cfg_q.field.period) begin
          ctr_q <= '0;
        end else begin
          ctr_q <= ctr_q + PWM_CTR_W'(1);
        end
        out_q <= (ctr_q < cfg_q.field.pulse_width);
      end
    end

    assign cfg_raw[n] = cfg_q.raw;
    assign pwm_o[n]   = out_q;
  end

  // Offsets past the last channel read zero
  always_comb begin
    rdata_o = '0;
    for (int n = 0; n < PwmWidth; n++) begin
      if (ch_idx == n) rdata_o = cfg_raw[n];
    end
  end

endmodule

// File: hw/gpio_regs.sv
// *********************************************************
// GPIO output register and synchronized input register
// *********************************************************
`timescale 1ns/1ns

module gpio_regs #(
  parameter int GpiWidth = 8,
  parameter int GpoWidth = 16
) (
  input  logic                         clk_sys_i,
  input  logic                         rst_sys_ni,

  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [bus_pkg::OFFSET_W-1:0] offset_i,
  input  logic [bus_pkg::BUS_BEW-1:0]  be_i,
  input  logic [bus_pkg::BUS_DW-1:0]   wdata_i,
  output logic [bus_pkg::BUS_DW-1:0]   rdata_o,

  input  logic [GpiWidth-1:0]          gp_i,
  output logic [GpoWidth-1:0]          gp_o
);

  import bus_pkg::*;

  logic [GpoWidth-1:0] gpo_q;
  logic [BUS_DW-1:0]   gpo_merged;
  logic [GpiWidth-1:0] gpi_meta_q;  // First synchronizer stage
  logic [GpiWidth-1:0] gpi_sync_q;

  assign gpo_merged = be_merge(BUS_DW'(gpo_q), wdata_i, be_i);

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpo_q      <= '0;
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
    end else begin
      gpi_meta_q <= gp_i;
      gpi_sync_q <= gpi_meta_q;
      if (req_i && we_i && (offset_i == GPIO_OUT_OFS)) gpo_q <= gpo_merged[GpoWidth-1:0];
    end
  end

  always_comb begin
    case (offset_i)
      GPIO_OUT_OFS: rdata_o = BUS_DW'(gpo_q);
      GPIO_IN_OFS:  rdata_o = BUS_DW'(gpi_sync_q);  // Zero-extended
      default:      rdata_o = '0;
    endcase
  end

  assign gp_o = gpo_q;

endmodule

// File: hw/mtimer.sv
// *********************************************************
// Machine timer: 64-bit mtime and mtimecmp with interrupt
// *********************************************************
`timescale 1ns/1ns

module mtimer (
  input  logic                         clk_sys_i,
  input  logic                         rst_sys_ni,

  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [bus_pkg::OFFSET_W-1:0] offset_i,
  input  logic [bus_pkg::BUS_BEW-1:0]  be_i,
  input  logic [bus_pkg::BUS_DW-1:0]   wdata_i,
  output logic [bus_pkg::BUS_DW-1:0]   rdata_o,

  output logic                         timer_irq_o
);

  import bus_pkg::*;

  localparam int TimeWidth = 2 * BUS_DW;

  logic [TimeWidth-1:0] mtime_q;
  logic [TimeWidth-1:0] mtime_d;
  logic [TimeWidth-1:0] mtimecmp_q;
  logic [TimeWidth-1:0] mtimecmp_d;
  logic                 irq_q;

  always_comb begin
    mtime_d    = mtime_q + TimeWidth'(1);
    mtimecmp_d = mtimecmp_q;
    if (req_i && we_i) begin
      // A time write replaces this cycle's increment
      case (offset_i)
        MTIME_LO_OFS: begin
          mtime_d = {mtime_q[TimeWidth-1:BUS_DW], be_merge(mtime_q[BUS_DW-1:0], wdata_i, be_i)};
        end
        MTIME_HI_OFS: begin
          mtime_d = {be_merge(mtime_q[TimeWidth-1:BUS_DW], wdata_i, be_i), mtime_q[BUS_DW-1:0]};
        end
        MTIMECMP_LO_OFS: mtimecmp_d[BUS_DW-1:0] = be_merge(mtimecmp_q[BUS_DW-1:0], wdata_i, be_i);
        MTIMECMP_HI_OFS: begin
          mtimecmp_d[TimeWidth-1:BUS_DW] = be_merge(mtimecmp_q[TimeWidth-1:BUS_DW], wdata_i, be_i);
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;    // Compare far away, no interrupt
      irq_q      <= 1'b0;
    end else begin
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      irq_q      <= (mtime_q >= mtimecmp_q);
    end
  end

  always_comb begin
    case (offset_i)
      MTIME_LO_OFS:    rdata_o = mtime_q[BUS_DW-1:0];
      MTIME_HI_OFS:    rdata_o = mtime_q[TimeWidth-1:BUS_DW];
      MTIMECMP_LO_OFS: rdata_o = mtimecmp_q[BUS_DW-1:0];
      MTIMECMP_HI_OFS: rdata_o = mtimecmp_q[TimeWidth-1:BUS_DW];
      default:         rdata_o = '0;
    endcase
  end

  assign timer_irq_o = irq_q;

endmodule

// File: hw/periph_bus_ctrl.sv
// *********************************************************
// Peripheral bus controller: request/grant FSM, base/mask
// address decode and registered read-data return
// *********************************************************
`timescale 1ns/1ns

module periph_bus_ctrl (
  input  logic                                clk_sys_i,
  input  logic                                rst_sys_ni,

  input  logic                                host_req_i,
  output logic                                host_gnt_o,
  input  logic [bus_pkg::BUS_AW-1:0]          host_addr_i,
  input  logic                                host_we_i,
  input  logic [bus_pkg::BUS_BEW-1:0]         host_be_i,
  input  logic [bus_pkg::BUS_DW-1:0]          host_wdata_i,
  output logic                                host_rvalid_o,
  output logic [bus_pkg::BUS_DW-1:0]          host_rdata_o,
  output logic                                host_err_o,

  output logic [soc_map_pkg::NR_DEVICES-1:0]  dev_req_o,
  output logic [bus_pkg::OFFSET_W-1:0]        dev_offset_o,
  output logic                                dev_we_o,
  output logic [bus_pkg::BUS_BEW-1:0]         dev_be_o,
  output logic [bus_pkg::BUS_DW-1:0]          dev_wdata_o,
  input  logic [bus_pkg::BUS_DW-1:0]          dev_rdata_i [soc_map_pkg::NR_DEVICES]
);

  import soc_map_pkg::*;
  import bus_pkg::*;

  localparam logic IDLE = 1'b0;
  localparam logic RESP = 1'b1;

  logic                  state_q;
  logic                  state_d;
  logic                  accept;
  logic                  addr_err;
  logic [NR_DEVICES-1:0] dev_match;
  logic [BUS_AW-1:0]     dev_base [NR_DEVICES];
  logic [BUS_AW-1:0]     dev_mask [NR_DEVICES];
  logic [BUS_DW-1:0]     sel_rdata;
  logic [BUS_DW-1:0]     rdata_q;
  logic                  err_q;

  assign dev_base[Gpio]  = GPIO_START;
  assign dev_mask[Gpio]  = GPIO_MASK;
  assign dev_base[Timer] = TIMER_START;
  assign dev_mask[Timer] = TIMER_MASK;
  assign dev_base[Pwm]   = PWM_START;
  assign dev_mask[Pwm]   = PWM_MASK;

  // One-hot region match, empty for an unmapped address
  always_comb begin
    dev_match = '0;
    sel_rdata = '0;
    for (int i = 0; i < NR_DEVICES; i++) begin
      dev_match[i] = ((host_addr_i & dev_mask[i]) == dev_base[i]);
      if (dev_match[i]) sel_rdata = dev_rdata_i[i];
    end
  end

  assign addr_err   = ~|dev_match;
  assign host_gnt_o = host_req_i & (state_q == IDLE);  // Grant only while idle
  assign accept     = host_gnt_o;

  always_comb begin
    case (state_q)
      IDLE:    state_d = accept ? RESP : IDLE;
      default: state_d = IDLE;  // Response lasts a single cycle
    endcase
  end

  // Shared device-side signals, the request picks the target
  assign dev_req_o    = dev_match & {NR_DEVICES{accept}};
  assign dev_offset_o = host_addr_i[OFFSET_W-1:0];
  assign dev_we_o     = host_we_i;
  assign dev_be_o     = host_be_i;
  assign dev_wdata_o  = host_wdata_i;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      state_q <= IDLE;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      err_q   <= accept & addr_err;
    end
  end

  // Writes and errors return zero
  always_ff @(posedge clk_sys_i) begin
    if (accept) rdata_q <= host_we_i ? '0 : sel_rdata;
  end

  assign host_rvalid_o = (state_q == RESP);
  assign host_rdata_o  = rdata_q;
  assign host_err_o    = err_q;

endmodule

// File: hw/bus_pkg.sv
// *********************************************************
// Peripheral bus widths, register offsets, byte-enable merge
// and the PWM configuration word
// *********************************************************

package bus_pkg;

  localparam int BUS_AW   = 32;
  localparam int BUS_DW   = 32;
  localparam int BUS_BEW  = BUS_DW / 8;
  localparam int OFFSET_W = 12;  // Offset inside a 4 KiB region

  localparam logic [OFFSET_W-1:0] GPIO_OUT_OFS    = 12'h000;
  localparam logic [OFFSET_W-1:0] GPIO_IN_OFS     = 12'h004;

  localparam logic [OFFSET_W-1:0] MTIME_LO_OFS    = 12'h000;
  localparam logic [OFFSET_W-1:0] MTIME_HI_OFS    = 12'h004;
  localparam logic [OFFSET_W-1:0] MTIMECMP_LO_OFS = 12'h008;
  localparam logic [OFFSET_W-1:0] MTIMECMP_HI_OFS = 12'h00C;

  localparam int PWM_CTR_W = 16;

  // One PWM channel word, raw on the bus and split for the channel logic
  typedef union packed {
    logic [BUS_DW-1:0] raw;
    struct packed {
      logic [PWM_CTR_W-1:0] pulse_width;  // Upper half
      logic [PWM_CTR_W-1:0] period;       // Lower half
    } field;
  } pwm_cfg_u;

  // Replace the enabled bytes of a register word with write data
  function automatic logic [BUS_DW-1:0] be_merge(input logic [BUS_DW-1:0]  old_word,
                                                 input logic [BUS_DW-1:0]  new_word,
                                                 input logic [BUS_BEW-1:0] be);
    logic [BUS_DW-1:0] merged;
    merged = old_word;
    for (int b = 0; b < BUS_BEW; b++) begin
      if (be[b]) merged[8*b +: 8] = new_word[8*b +: 8];
    end
    return merged;
  endfunction

endpackage

// File: hw/soc_map_pkg.sv
// *********************************************************
// Peripheral memory map of the subsystem: device enumeration,
// region bases, sizes and decode masks
// *********************************************************

package soc_map_pkg;

  // Devices on the peripheral bus, also the index into per-device arrays
  typedef enum int {
    Gpio,
    Timer,
    Pwm
  } periph_dev_e;

  localparam int NR_DEVICES = 3;

  // GPIO region
  localparam logic [31:0] GPIO_START  = 32'h8000_0000;
  localparam logic [31:0] GPIO_SIZE   = 32'h0000_1000;  // 4 KiB
  localparam logic [31:0] GPIO_MASK   = ~(GPIO_SIZE - 32'd1);

  // Machine timer region
  localparam logic [31:0] TIMER_START = 32'h8000_2000;
  localparam logic [31:0] TIMER_SIZE  = 32'h0000_1000;  // 4 KiB
  localparam logic [31:0] TIMER_MASK  = ~(TIMER_SIZE - 32'd1);

  // PWM region
  localparam logic [31:0] PWM_START   = 32'h8000_3000;
  localparam logic [31:0] PWM_SIZE    = 32'h0000_1000;  // 4 KiB
  localparam logic [31:0] PWM_MASK    = ~(PWM_SIZE - 32'd1);

  // 0x8000_1000 stays a hole, decoded as an error

endpackage
